// ==== run_sim.sh ====
#!/bin/sh
# build and run the soc_bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_soc_bus -f tb.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_soc_bus > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TESTS PASSED" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== source/bus_request_decode.sv ====
`default_nettype none

module bus_request_decode #(
    parameter int RAM_WORDS = soc_bus_pkg::DEF_RAM_WORDS
) (
    input  wire                          sys_CLK,
    input  wire                          KEY0,
    input  wire                          req_read,
    input  wire                          req_write,
    input  wire [soc_bus_pkg::XLEN-1:0]  req_addr,
    input  wire soc_bus_pkg::ls_type_e   req_ls_type,
    input  wire [soc_bus_pkg::XLEN-1:0]  req_wdata,
    output logic                         acc_go,
    output logic                         acc_last,
    output logic                         acc_write,
    output logic                         acc_beat,    // second word of a doubleword
    output logic [soc_bus_pkg::XLEN-1:0] acc_addr,
    output soc_bus_pkg::ls_type_e        acc_ls_type,
    output logic [soc_bus_pkg::XLEN-1:0] acc_wdata,
    output soc_bus_pkg::region_e         acc_region
);
    import soc_bus_pkg::*;

    localparam logic [XLEN-1:0] RAM_END  = RAM_BASE + XLEN'(4 * RAM_WORDS);
    localparam logic [XLEN-1:0] PLIC_END = PLIC_BASE + PLIC_SPAN;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BEAT,    // one acc_go per edge spent here
        ST_FINISH   // wait for the response stage
    } state_e;

    state_e  state;
    region_e req_region;
    logic    req_take;
    logic    two_beats;

    assign req_take  = (state == ST_IDLE) && (req_read || req_write);
    assign two_beats = (acc_region == RGN_RAM) && (acc_ls_type == LS_D);

    // address map
    always_comb begin
        if (req_addr >= RAM_BASE && req_addr < RAM_END) begin
            req_region = RGN_RAM;
        end else if (req_addr >= PLIC_BASE && req_addr < PLIC_END) begin
            req_region = RGN_PLIC;
        end else if (req_addr == MTIMECMP_ADDR) begin
            req_region = RGN_MTIMECMP;
        end else begin
            req_region = RGN_NONE;
        end
    end

    always_ff @(posedge sys_CLK) begin
        if (req_take) begin
            acc_addr    <= req_addr;
            acc_ls_type <= req_ls_type;
            acc_wdata   <= req_wdata;
        end
    end

    always_ff @(posedge sys_CLK or negedge KEY0) begin
        if (!KEY0) begin
            state      <= ST_IDLE;
            acc_go     <= 1'b0;
            acc_last   <= 1'b0;
            acc_beat   <= 1'b0;
            acc_write  <= 1'b0;
            acc_region <= RGN_NONE;
        end else begin
            acc_go   <= 1'b0;
            acc_last <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (req_take) begin
                        acc_write  <= req_write;   // write wins if both strobes set
                        acc_region <= req_region;
                        acc_beat   <= 1'b0;
                        state      <= ST_BEAT;
                    end
                end
                ST_BEAT: begin
                    acc_go <= 1'b1;
                    if (!two_beats || acc_go) begin
                        // single beat, or the second word of a doubleword
                        acc_last <= 1'b1;
                        acc_beat <= two_beats;
                        state    <= ST_FINISH;
                    end
                end
                ST_FINISH: begin
                    if (!acc_last) state <= ST_IDLE;  // response fires on this edge
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/bus_response.sv ====
`default_nettype none

module bus_response (
    input  wire                          sys_CLK,
    input  wire                          KEY0,
    input  wire                          acc_last,
    input  wire                          acc_write,
    input  wire soc_bus_pkg::region_e    acc_region,
    input  wire [soc_bus_pkg::XLEN-1:0]  ram_rdata,
    input  wire [soc_bus_pkg::XLEN-1:0]  regs_rdata,
    output logic                         rsp_valid,
    output logic [soc_bus_pkg::XLEN-1:0] rsp_rdata
);
    import soc_bus_pkg::*;

    logic            last_d;   // target data settles one edge after acc_last
    logic [XLEN-1:0] sel_data;

    always_comb begin
        case (acc_region)
            RGN_RAM:      sel_data = ram_rdata;
            RGN_PLIC:     sel_data = regs_rdata;
            RGN_MTIMECMP: sel_data = regs_rdata;
            default:      sel_data = '0;   // unmapped reads return zero
        endcase
        if (acc_write) sel_data = '0;
    end

    always_ff @(posedge sys_CLK or negedge KEY0) begin
        if (!KEY0) begin
            last_d    <= 1'b0;
            rsp_valid <= 1'b0;
            rsp_rdata <= '0;
        end else begin
            last_d    <= acc_last;
            rsp_valid <= last_d;
            if (last_d) rsp_rdata <= sel_data;  // held until the next response
        end
    end

endmodule

`default_nettype wire

// ==== source/plic_mtimecmp_regs.sv ====
`default_nettype none

module plic_mtimecmp_regs (
    input  wire                          sys_CLK,
    input  wire                          KEY0,
    input  wire                          acc_go,
    input  wire                          acc_write,
    input  wire [soc_bus_pkg::XLEN-1:0]  acc_addr,
    input  wire [soc_bus_pkg::XLEN-1:0]  acc_wdata,
    input  wire soc_bus_pkg::region_e    acc_region,
    input  wire                          irq_src,
    output logic [soc_bus_pkg::XLEN-1:0] regs_rdata,
    output logic                         meip,
    output logic                         msip
);
    import soc_bus_pkg::*;

    localparam int ID_W = $clog2(PLIC_SOURCES);

    logic [PRIO_W-1:0]       prio      [PLIC_SOURCES];
    logic [PLIC_SOURCES-1:0] pending;
    logic [31:0]             enable    [PLIC_CONTEXTS];
    logic [PRIO_W-1:0]       threshold [PLIC_CONTEXTS];  // stored only, no gating
    logic [XLEN-1:0]         mtimecmp;

    logic            irq_meta;
    logic            irq_sync;
    logic            irq_prev;
    logic [XLEN-1:0] ofs;
    logic [ID_W-1:0] prio_id;
    logic            sel_prio;
    logic            sel_pend;
    logic [PLIC_CONTEXTS-1:0] sel_en;
    logic [PLIC_CONTEXTS-1:0] sel_th;
    logic [PLIC_CONTEXTS-1:0] sel_claim;
    logic [PLIC_CONTEXTS-1:0] claim_hit;   // source 1 claimable per context
    logic            plic_go;
    logic            mtc_go;

    assign ofs      = acc_addr - PLIC_BASE;
    assign prio_id  = ofs[ID_W+1:2];
    assign sel_prio = (ofs < PLIC_PENDING_OFS) && (ofs[XLEN-1:2] < PLIC_SOURCES);
    assign sel_pend = (ofs == PLIC_PENDING_OFS);
    assign plic_go  = acc_go && (acc_region == RGN_PLIC);
    assign mtc_go   = acc_go && (acc_region == RGN_MTIMECMP);

    always_comb begin
        for (int c = 0; c < PLIC_CONTEXTS; c++) begin
            sel_en[c]    = (ofs == PLIC_ENABLE_OFS + XLEN'(c) * PLIC_CTX_ENABLE_STRIDE);
            sel_th[c]    = (ofs == PLIC_THRESH_OFS + XLEN'(c) * PLIC_CTX_STRIDE);
            sel_claim[c] = (ofs == PLIC_CLAIM_OFS + XLEN'(c) * PLIC_CTX_STRIDE);
            claim_hit[c] = pending[1] && enable[c][1];
        end
    end

    assign meip = claim_hit[0];
    assign msip = claim_hit[1];

    // read path, registered on the access edge
    always_ff @(posedge sys_CLK) begin
        if (acc_go && !acc_write) begin
            regs_rdata <= '0;
            if (acc_region == RGN_MTIMECMP) begin
                regs_rdata <= mtimecmp;
            end else if (acc_region == RGN_PLIC) begin
                if (sel_prio) regs_rdata <= XLEN'(prio[prio_id]);
                if (sel_pend) regs_rdata <= XLEN'(pending);
                for (int c = 0; c < PLIC_CONTEXTS; c++) begin
                    if (sel_en[c])    regs_rdata <= XLEN'(enable[c]);
                    if (sel_th[c])    regs_rdata <= XLEN'(threshold[c]);
                    if (sel_claim[c]) regs_rdata <= XLEN'(claim_hit[c]);  // id 1 or 0
                end
            end
        end
    end

    always_ff @(posedge sys_CLK or negedge KEY0) begin
        if (!KEY0) begin
            irq_meta <= 1'b0;
            irq_sync <= 1'b0;
            irq_prev <= 1'b0;
            pending  <= '0;
            mtimecmp <= MTIMECMP_RESET;
            for (int i = 0; i < PLIC_SOURCES; i++) begin
                prio[i] <= '0;
            end
            for (int c = 0; c < PLIC_CONTEXTS; c++) begin
                enable[c]    <= '0;
                threshold[c] <= '0;
            end
        end else begin
            irq_meta <= irq_src;  // two flop sync
            irq_sync <= irq_meta;
            irq_prev <= irq_sync;

            if (mtc_go && acc_write) mtimecmp <= acc_wdata;

            if (plic_go && acc_write) begin
                if (sel_prio) prio[prio_id] <= acc_wdata[PRIO_W-1:0];
                for (int c = 0; c < PLIC_CONTEXTS; c++) begin
                    if (sel_en[c]) enable[c] <= acc_wdata[31:0];
                    if (sel_th[c]) threshold[c] <= acc_wdata[PRIO_W-1:0];
                end
                // claim writes just complete
            end

            if (plic_go && !acc_write) begin
                for (int c = 0; c < PLIC_CONTEXTS; c++) begin
                    if (sel_claim[c] && claim_hit[c]) pending[1] <= 1'b0;
                end
            end

            // a fresh edge re-arms even during a claim
            if (irq_sync && !irq_prev) pending[1] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/scratch_ram.sv ====
`default_nettype none

module scratch_ram #(
    parameter int RAM_WORDS = soc_bus_pkg::DEF_RAM_WORDS
) (
    input  wire                          sys_CLK,
    input  wire                          acc_go,
    input  wire                          acc_write,
    input  wire                          acc_beat,
    input  wire [soc_bus_pkg::XLEN-1:0]  acc_addr,
    input  wire soc_bus_pkg::ls_type_e   acc_ls_type,
    input  wire [soc_bus_pkg::XLEN-1:0]  acc_wdata,
    input  wire soc_bus_pkg::region_e    acc_region,
    output logic [soc_bus_pkg::XLEN-1:0] ram_rdata
);
    import soc_bus_pkg::*;

    localparam int IDX_W = $clog2(RAM_WORDS);
    localparam int LANES = WORD_W / 8;

    logic [WORD_W-1:0] mem [RAM_WORDS];

    logic [XLEN-1:0]   ram_ofs;
    logic [IDX_W-1:0]  word_idx;
    logic [1:0]        byte_ofs;
    logic [LANES-1:0]  wr_be;
    logic [WORD_W-1:0] wr_word;
    logic [WORD_W-1:0] rd_word;
    logic [WORD_W-1:0] rd_shift;
    logic              ram_sel;

    assign ram_sel  = acc_go && (acc_region == RGN_RAM);
    assign ram_ofs  = acc_addr - RAM_BASE;
    assign byte_ofs = ram_ofs[1:0];
    assign word_idx = ram_ofs[IDX_W+1:2] + IDX_W'(acc_beat);  // beat 1 takes the next word
    assign rd_word  = mem[word_idx];
    assign rd_shift = rd_word >> {byte_ofs, 3'b000};

    // store lanes, data replicated so each lane sees its bytes
    always_comb begin
        wr_be   = '0;
        wr_word = acc_wdata[WORD_W-1:0];
        case (acc_ls_type)
            LS_B: begin
                wr_be   = LANES'(1) << byte_ofs;
                wr_word = {LANES{acc_wdata[7:0]}};
            end
            LS_H: begin
                wr_be   = byte_ofs[1] ? LANES'(4'b1100) : LANES'(4'b0011);
                wr_word = {2{acc_wdata[15:0]}};
            end
            LS_W: begin
                wr_be = '1;
            end
            LS_D: begin
                wr_be   = '1;
                wr_word = acc_beat ? acc_wdata[XLEN-1:WORD_W] : acc_wdata[WORD_W-1:0];
            end
            default: wr_be = '0;  // unsigned codes are loads only
        endcase
    end

    always_ff @(posedge sys_CLK) begin
        if (ram_sel && acc_write) begin
            for (int b = 0; b < LANES; b++) begin
                if (wr_be[b]) mem[word_idx][8*b +: 8] <= wr_word[8*b +: 8];
            end
        end
    end

    always_ff @(posedge sys_CLK) begin
        if (ram_sel && !acc_write) begin
            case (acc_ls_type)
                LS_B:  ram_rdata <= {{(XLEN-8){rd_shift[7]}}, rd_shift[7:0]};
                LS_BU: ram_rdata <= {{(XLEN-8){1'b0}}, rd_shift[7:0]};
                LS_H:  ram_rdata <= {{(XLEN-16){rd_shift[15]}}, rd_shift[15:0]};
                LS_HU: ram_rdata <= {{(XLEN-16){1'b0}}, rd_shift[15:0]};
                LS_W:  ram_rdata <= {{(XLEN-WORD_W){rd_word[WORD_W-1]}}, rd_word};
                LS_WU: ram_rdata <= {{(XLEN-WORD_W){1'b0}}, rd_word};
                LS_D: begin
                    // low word first, high word on the second beat
                    if (acc_beat) ram_rdata[XLEN-1:WORD_W] <= rd_word;
                    else          ram_rdata[WORD_W-1:0] <= rd_word;
                end
                default: ram_rdata <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/soc_bus_pkg.sv ====
`default_nettype none

package soc_bus_pkg;

    // bus and memory widths
    parameter int XLEN   = 64;
    parameter int WORD_W = 32;

    // scratch RAM
    parameter logic [XLEN-1:0] RAM_BASE = 64'h0000_0000_8000_0000;
    parameter int DEF_RAM_WORDS = 2048;

    // PLIC window and register offsets from PLIC_BASE
    parameter logic [XLEN-1:0] PLIC_BASE              = 64'h0000_0000_0C00_0000;
    parameter logic [XLEN-1:0] PLIC_PENDING_OFS       = 64'h1000;
    parameter logic [XLEN-1:0] PLIC_ENABLE_OFS        = 64'h2000;
    parameter logic [XLEN-1:0] PLIC_CTX_ENABLE_STRIDE = 64'h80;
    parameter logic [XLEN-1:0] PLIC_THRESH_OFS        = 64'h20_0000;
    parameter logic [XLEN-1:0] PLIC_CTX_STRIDE        = 64'h1000;
    parameter logic [XLEN-1:0] PLIC_CLAIM_OFS         = 64'h20_0004;
    parameter logic [XLEN-1:0] PLIC_SPAN              = 64'h40_0000;

    parameter int PLIC_SOURCES  = 6;  // id 0 is reserved
    parameter int PLIC_CONTEXTS = 2;  // ctx 0 machine, ctx 1 supervisor
    parameter int PRIO_W        = 3;

    // machine timer compare
    parameter logic [XLEN-1:0] MTIMECMP_ADDR  = 64'h0000_0000_0200_4000;
    parameter logic [XLEN-1:0] MTIMECMP_RESET = 64'h0000_0000_8000_0000;

    // RISC-V load/store width codes, funct3 style
    typedef enum logic [2:0] {
        LS_B  = 3'd0,
        LS_H  = 3'd1,
        LS_W  = 3'd2,
        LS_D  = 3'd3,
        LS_BU = 3'd4,
        LS_HU = 3'd5,
        LS_WU = 3'd6
    } ls_type_e;

    typedef enum logic [1:0] {
        RGN_NONE,
        RGN_RAM,
        RGN_PLIC,
        RGN_MTIMECMP
    } region_e;

endpackage

`default_nettype wire

// ==== source/soc_bus_top.sv ====
`default_nettype none

module soc_bus_top #(
    parameter int RAM_WORDS = soc_bus_pkg::DEF_RAM_WORDS
) (
    input  wire                          sys_CLK,
    input  wire                          KEY0,
    input  wire                          req_read,
    input  wire                          req_write,
    input  wire [soc_bus_pkg::XLEN-1:0]  req_addr,
    input  wire soc_bus_pkg::ls_type_e   req_ls_type,
    input  wire [soc_bus_pkg::XLEN-1:0]  req_wdata,
    input  wire                          irq_src,     // async interrupt line
    output logic                         rsp_valid,
    output logic [soc_bus_pkg::XLEN-1:0] rsp_rdata,
    output logic                         meip,
    output logic                         msip
);
    import soc_bus_pkg::*;

    logic            acc_go;
    logic            acc_last;
    logic            acc_write;
    logic            acc_beat;
    logic [XLEN-1:0] acc_addr;
    ls_type_e        acc_ls_type;
    logic [XLEN-1:0] acc_wdata;
    region_e         acc_region;

    logic [XLEN-1:0] ram_rdata;
    logic [XLEN-1:0] regs_rdata;

    bus_request_decode #(
        .RAM_WORDS (RAM_WORDS)
    ) u_bus_request_decode (
        .sys_CLK     (sys_CLK),
        .KEY0        (KEY0),
        .req_read    (req_read),
        .req_write   (req_write),
        .req_addr    (req_addr),
        .req_ls_type (req_ls_type),
        .req_wdata   (req_wdata),
        .acc_go      (acc_go),
        .acc_last    (acc_last),
        .acc_write   (acc_write),
        .acc_beat    (acc_beat),
        .acc_addr    (acc_addr),
        .acc_ls_type (acc_ls_type),
        .acc_wdata   (acc_wdata),
        .acc_region  (acc_region)
    );

    scratch_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) u_scratch_ram (
        .sys_CLK     (sys_CLK),
        .acc_go      (acc_go),
        .acc_write   (acc_write),
        .acc_beat    (acc_beat),
        .acc_addr    (acc_addr),
        .acc_ls_type (acc_ls_type),
        .acc_wdata   (acc_wdata),
        .acc_region  (acc_region),
        .ram_rdata   (ram_rdata)
    );

    plic_mtimecmp_regs u_plic_mtimecmp_regs (
        .sys_CLK    (sys_CLK),
        .KEY0       (KEY0),
        .acc_go     (acc_go),
        .acc_write  (acc_write),
        .acc_addr   (acc_addr),
        .acc_wdata  (acc_wdata),
        .acc_region (acc_region),
        .irq_src    (irq_src),
        .regs_rdata (regs_rdata),
        .meip       (meip),
        .msip       (msip)
    );

    bus_response u_bus_response (
        .sys_CLK    (sys_CLK),
        .KEY0       (KEY0),
        .acc_last   (acc_last),
        .acc_write  (acc_write),
        .acc_region (acc_region),
        .ram_rdata  (ram_rdata),
        .regs_rdata (regs_rdata),
        .rsp_valid  (rsp_valid),
        .rsp_rdata  (rsp_rdata)
    );

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
source/soc_bus_pkg.sv
source/bus_request_decode.sv
source/scratch_ram.sv
source/plic_mtimecmp_regs.sv
source/bus_response.sv
source/soc_bus_top.sv
tests/tb_soc_bus.sv

// ==== include/tb_soc_bus_tasks.svh ====
`ifndef TB_SOC_BUS_TASKS_SVH
`define TB_SOC_BUS_TASKS_SVH

localparam int RSP_TIMEOUT = 20;  // cycles from strobe to rsp_valid
localparam int IRQ_TIMEOUT = 20;  // cycles from irq_src rise to meip or msip

task automatic check(input string what, input logic [63:0] expected,
                     input logic [63:0] actual);
    if (expected !== actual) begin
        $display("Fail %s %s expected 0x%016h actual 0x%016h",
                 cur_test, what, expected, actual);
        errors++;
    end
endtask

// ends the current test and hands the run to the abort watcher
task automatic abort_run(input string why);
    $display("%s: %s", cur_test, why);
    errors++;
    tests_failed++;
    -> abort_ev;
    forever @(negedge sys_CLK);  // parked until the watcher ends the run
endtask

// counts edges from the strobe sample to rsp_valid
task automatic wait_rsp;
    last_lat = 0;
    while (!rsp_valid) begin
        if (last_lat >= RSP_TIMEOUT) abort_run("no response within timeout");
        @(negedge sys_CLK);
        last_lat++;
    end
endtask

task automatic wait_irq(input bit ctx);
    int n;
    n = 0;
    while ((ctx ? msip : meip) !== 1'b1) begin
        if (n >= IRQ_TIMEOUT) abort_run("interrupt line not raised within timeout");
        @(negedge sys_CLK);
        n++;
    end
endtask

// drives one strobe cycle and returns on the falling edge that sees rsp_valid
task automatic transfer(input logic wr, input logic [63:0] addr, input ls_type_e ls,
                        input logic [63:0] wdata, output logic [63:0] rdata);
    req_read    = !wr;
    req_write   = wr;
    req_addr    = addr;
    req_ls_type = ls;
    req_wdata   = wdata;
    @(negedge sys_CLK);
    req_read  = 1'b0;
    req_write = 1'b0;
    wait_rsp();
    rdata = rsp_rdata;
endtask

task automatic bus_write(input logic [63:0] addr, input ls_type_e ls, input logic [63:0] wdata);
    logic [63:0] rdata;
    transfer(1'b1, addr, ls, wdata, rdata);
    check("write response data", 64'h0, rdata);
endtask

task automatic bus_read(input logic [63:0] addr, input ls_type_e ls, output logic [63:0] rdata);
    transfer(1'b0, addr, ls, 64'h0, rdata);
endtask

`endif

// ==== tests/tb_soc_bus.sv ====
`default_nettype none

module tb_soc_bus;
    import soc_bus_pkg::*;

    logic            sys_CLK = 1'b0;
    logic            KEY0;
    logic            req_read;
    logic            req_write;
    logic [XLEN-1:0] req_addr;
    ls_type_e        req_ls_type;
    logic [XLEN-1:0] req_wdata;
    logic            irq_src;
    wire             rsp_valid;
    wire [XLEN-1:0]  rsp_rdata;
    wire             meip;
    wire             msip;

    int    errors = 0;
    int    tests_passed = 0;
    int    tests_failed = 0;
    int    errors_at_start = 0;
    int    last_lat = 0;     // edges from strobe sample to rsp_valid
    string cur_test = "reset";
    event  abort_ev;         // raised when a wait runs out of time

    soc_bus_top u_soc_bus_top (
        .sys_CLK     (sys_CLK),
        .KEY0        (KEY0),
        .req_read    (req_read),
        .req_write   (req_write),
        .req_addr    (req_addr),
        .req_ls_type (req_ls_type),
        .req_wdata   (req_wdata),
        .irq_src     (irq_src),
        .rsp_valid   (rsp_valid),
        .rsp_rdata   (rsp_rdata),
        .meip        (meip),
        .msip        (msip)
    );

    `include "tb_soc_bus_tasks.svh"

    initial begin
        forever #50 sys_CLK = ~sys_CLK;
    end

    // closes the run after a timeout
    initial begin
        @(abort_ev);
        finish_run();
    end

    // sign or zero extension of the low bits of v
    function automatic logic [63:0] extend(input logic [31:0] v, input int bits, input bit sgn);
        logic [63:0] r;
        r = 64'(v);
        for (int i = bits; i < 64; i++) r[i] = sgn ? v[bits-1] : 1'b0;
        return r;
    endfunction

    function automatic logic [63:0] enable_addr(input int c);
        return PLIC_BASE + PLIC_ENABLE_OFS + 64'(c) * PLIC_CTX_ENABLE_STRIDE;
    endfunction

    function automatic logic [63:0] claim_addr(input int c);
        return PLIC_BASE + PLIC_CLAIM_OFS + 64'(c) * PLIC_CTX_STRIDE;
    endfunction

    task automatic start_test(input string name);
        cur_test        = name;
        errors_at_start = errors;
    endtask

    task automatic end_test;
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("%s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", cur_test, errors - errors_at_start);
        end
    endtask

    task automatic finish_run;
        $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    task automatic mtimecmp_rw;
        logic [63:0] wdata;
        logic [63:0] rdata;
        start_test("mtimecmp");
        check("rsp_valid after reset", 64'h0, 64'(rsp_valid));
        check("meip after reset", 64'h0, 64'(meip));
        check("msip after reset", 64'h0, 64'(msip));
        bus_read(MTIMECMP_ADDR, LS_D, rdata);
        check("reset value", MTIMECMP_RESET, rdata);
        check("read latency", 64'd3, 64'(last_lat));
        wdata = {$urandom, $urandom};
        bus_write(MTIMECMP_ADDR, LS_D, wdata);
        bus_read(MTIMECMP_ADDR, LS_D, rdata);
        check("readback", wdata, rdata);
        end_test();
    endtask

    task automatic ram_word_dword;
        logic [63:0] addr;
        logic [63:0] wdata;
        logic [63:0] rdata;
        start_test("ram word and doubleword");
        for (int i = 0; i < 8; i++) begin
            addr  = RAM_BASE + 64'(4 * ($urandom % DEF_RAM_WORDS));
            wdata = {$urandom, $urandom};
            if (i[0]) wdata[31] = 1'b1;  // negative words on odd passes
            bus_write(addr, LS_W, wdata);
            check("word write latency", 64'd3, 64'(last_lat));
            bus_read(addr, LS_W, rdata);
            check("word read latency", 64'd3, 64'(last_lat));
            check("word readback", extend(wdata[31:0], 32, 1'b1), rdata);

            addr  = RAM_BASE + 64'(8 * ($urandom % (DEF_RAM_WORDS / 2)));
            wdata = {$urandom, $urandom};
            bus_write(addr, LS_D, wdata);
            check("dword write latency", 64'd4, 64'(last_lat));
            bus_read(addr, LS_D, rdata);
            check("dword read latency", 64'd4, 64'(last_lat));
            check("dword readback", wdata, rdata);
        end
        end_test();
    endtask

    task automatic subword_access;
        logic [63:0] addr;
        logic [31:0] model;     // expected contents of the word
        logic [31:0] shifted;
        logic [7:0]  b;
        logic [15:0] h;
        logic [63:0] rdata;
        start_test("sub-word stores and loads");
        addr  = RAM_BASE + 64'h100;
        model = 32'h1234_5678;
        bus_write(addr, LS_W, 64'(model));
        for (int ofs = 0; ofs < 4; ofs++) begin
            b = 8'($urandom);
            if (ofs[0]) b[7] = 1'b1;
            bus_write(addr + 64'(ofs), LS_B, {$urandom, 24'($urandom), b});  // junk above the lane
            model[8*ofs +: 8] = b;
            shifted = model >> (8 * ofs);
            bus_read(addr + 64'(ofs), LS_B, rdata);
            check("LS_B", extend(shifted, 8, 1'b1), rdata);
            bus_read(addr + 64'(ofs), LS_BU, rdata);
            check("LS_BU", extend(shifted, 8, 1'b0), rdata);
        end
        for (int ofs = 0; ofs < 4; ofs += 2) begin
            h = 16'($urandom);
            h[15] = (ofs == 2);
            bus_write(addr + 64'(ofs), LS_H, {$urandom, 16'($urandom), h});
            model[8*ofs +: 16] = h;
            shifted = model >> (8 * ofs);
            bus_read(addr + 64'(ofs), LS_H, rdata);
            check("LS_H", extend(shifted, 16, 1'b1), rdata);
            bus_read(addr + 64'(ofs), LS_HU, rdata);
            check("LS_HU", extend(shifted, 16, 1'b0), rdata);
        end
        bus_read(addr, LS_WU, rdata);
        check("LS_WU", extend(model, 32, 1'b0), rdata);
        end_test();
    endtask

    task automatic plic_storage;
        logic [63:0] addr;
        logic [63:0] wdata;
        logic [63:0] rdata;
        start_test("plic storage");
        for (int id = 1; id < PLIC_SOURCES; id++) begin
            addr  = PLIC_BASE + 64'(4 * id);
            wdata = 64'($urandom);
            bus_write(addr, LS_W, wdata);
            bus_read(addr, LS_W, rdata);
            check("priority", 64'(wdata[PRIO_W-1:0]), rdata);
        end
        for (int c = 0; c < 2; c++) begin
            wdata = 64'($urandom);
            bus_write(enable_addr(c), LS_W, wdata);
            bus_read(enable_addr(c), LS_W, rdata);
            check("enable", wdata, rdata);
            addr  = PLIC_BASE + PLIC_THRESH_OFS + 64'(c) * PLIC_CTX_STRIDE;
            wdata = 64'($urandom % (1 << PRIO_W));
            bus_write(addr, LS_W, wdata);
            bus_read(addr, LS_W, rdata);
            check("threshold", wdata, rdata);
        end
        end_test();
    endtask

    task automatic irq_claim;
        logic [63:0] rdata;
        start_test("interrupt and claim");
        for (int c = 0; c < 2; c++) begin
            bus_write(enable_addr(c), LS_W, 64'h2);       // source 1 only
            bus_write(enable_addr(1 - c), LS_W, 64'h0);
            irq_src = 1'b1;
            wait_irq(c[0]);
            check("other context line", 64'h0, 64'(c ? meip : msip));
            irq_src = 1'b0;
            bus_read(claim_addr(c), LS_W, rdata);
            check("first claim", 64'h1, rdata);
            check("line after claim", 64'h0, 64'(c ? msip : meip));
            bus_read(PLIC_BASE + PLIC_PENDING_OFS, LS_W, rdata);
            check("pending after claim", 64'h0, rdata);
            bus_read(claim_addr(c), LS_W, rdata);
            check("second claim", 64'h0, rdata);
        end
        end_test();
    endtask

    task automatic unmapped_and_dropped;
        logic [63:0] addr;
        logic [63:0] rdata;
        logic [63:0] first_data;
        int          count;
        int          first_lat;
        start_test("unmapped and dropped requests");
        bus_read(64'h1000_0000, LS_D, rdata);
        check("unmapped read data", 64'h0, rdata);
        check("unmapped read latency", 64'd3, 64'(last_lat));

        addr = RAM_BASE + 64'h200;
        bus_write(addr, LS_W, 64'h5a5a_1234);
        req_read    = 1'b1;
        req_addr    = addr;
        req_ls_type = LS_W;
        req_wdata   = 64'h0;
        @(negedge sys_CLK);
        req_read  = 1'b0;
        req_write = 1'b1;  // arrives while busy
        req_wdata = 64'hdead_beef;
        count      = 0;
        first_lat  = 0;
        first_data = 64'h0;
        for (int n = 1; n <= 10; n++) begin
            @(negedge sys_CLK);
            req_write = 1'b0;
            if (rsp_valid) begin
                count++;
                if (count == 1) begin
                    first_lat  = n;
                    first_data = rsp_rdata;
                end
            end
        end
        check("response count", 64'd1, 64'(count));
        check("first request latency", 64'd3, 64'(first_lat));
        check("first request data", 64'h5a5a_1234, first_data);
        bus_read(addr, LS_W, rdata);
        check("word after dropped write", 64'h5a5a_1234, rdata);
        end_test();
    endtask

    initial begin
        void'($urandom(41945));
        KEY0        = 1'b0;
        req_read    = 1'b0;
        req_write   = 1'b0;
        req_addr    = '0;
        req_ls_type = LS_W;
        req_wdata   = '0;
        irq_src     = 1'b0;
        repeat (16) @(negedge sys_CLK);
        KEY0 = 1'b1;
        @(negedge sys_CLK);

        mtimecmp_rw();      // must see the reset value first
        ram_word_dword();
        subword_access();
        plic_storage();
        irq_claim();
        unmapped_and_dropped();
        finish_run();
    end

endmodule

`default_nettype wire
